/* design/byte_stream_if.sv */
`timescale 1ns/10ps

interface byte_stream_if;
    logic [7:0] data;
    logic       valid;
    logic       ready;
    // Side channel driven by whichever end owns it on this link
    wire        mark;

    modport source (
        output data,
        output valid,
        input  ready,
        inout  mark
    );

    modport sink (
        input  data,
        input  valid,
        output ready,
        inout  mark
    );

endinterface

/* design/history_buffer.sv */
`timescale 1ns/10ps

module history_buffer #(
    parameter int HIST_ADDR_W = 16
) (
    input  logic                   clk,
    input  logic                   wr_en,
    input  logic [HIST_ADDR_W-1:0] wr_addr,
    input  logic [7:0]             wr_data,
    input  logic [HIST_ADDR_W-1:0] rd_addr,
    output logic [7:0]             rd_data
);

    localparam int DEPTH = 1 << HIST_ADDR_W;

    logic [7:0] mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read one cycle behind the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* design/snappy_decoder.sv */
`timescale 1ns/10ps

module snappy_decoder #(
    parameter int HIST_ADDR_W = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    byte_stream_if.sink            in_bytes,
    byte_stream_if.source          out_bytes,
    output logic                   hist_wr_en,
    output logic [HIST_ADDR_W-1:0] hist_wr_addr,
    output logic [7:0]             hist_wr_data,
    output logic [HIST_ADDR_W-1:0] hist_rd_addr,
    input  logic [7:0]             hist_rd_data
);

    localparam logic [3:0] S_IDLE    = 4'd0;
    localparam logic [3:0] S_LEN     = 4'd1;
    localparam logic [3:0] S_TAG     = 4'd2;
    localparam logic [3:0] S_LITLEN  = 4'd3;
    localparam logic [3:0] S_LIT     = 4'd4;
    localparam logic [3:0] S_OFF_LO  = 4'd5;
    localparam logic [3:0] S_OFF_HI  = 4'd6;
    localparam logic [3:0] S_COPY_RD = 4'd7;
    localparam logic [3:0] S_COPY_WR = 4'd8;

    logic [3:0]             state;
    snappy_pkg::block_len_t remain;     // bytes left in the block
    snappy_pkg::block_len_t count;      // bytes left in the element
    logic [5:0]             len_shift;
    logic [1:0]             lb_cnt;
    logic [1:0]             lb_idx;
    logic                   short_off;
    logic [7:0]             off_q;
    logic [HIST_ADDR_W-1:0] wr_ptr;
    logic [HIST_ADDR_W-1:0] copy_src;

    snappy_pkg::tag_byte_u  tag;
    snappy_pkg::block_len_t len_next;
    snappy_pkg::block_len_t lit_len_next;
    logic [15:0]            offset;
    logic                   take_state;
    logic                   last_in;
    logic                   in_fire;
    logic                   out_fire;
    logic                   out_valid_c;
    logic [7:0]             out_data_c;

    ////////////////////////////////////////////////////////////
    // Byte decode
    ////////////////////////////////////////////////////////////

    assign tag          = snappy_pkg::tag_byte_u'(in_bytes.data);
    assign len_next     = remain | (snappy_pkg::block_len_t'(in_bytes.data[6:0]) << len_shift);
    assign lit_len_next = count | (snappy_pkg::block_len_t'(in_bytes.data) << {lb_idx, 3'b000});
    assign offset       = short_off ? {off_q, in_bytes.data} : {in_bytes.data, off_q};

    always_comb begin
        case (state)
            S_LEN, S_TAG, S_LITLEN, S_LIT, S_OFF_LO, S_OFF_HI: take_state = 1'b1;
            default: take_state = 1'b0;
        endcase
    end

    // Last input byte of the block drops the tail of its word
    always_comb begin
        case (state)
            S_LEN:    last_in = ~in_bytes.data[7] && (len_next == '0);
            S_LIT:    last_in = (remain == 1);
            S_OFF_LO: last_in = short_off && (count >= remain);
            S_OFF_HI: last_in = (count >= remain);
            default:  last_in = 1'b0;
        endcase
    end

    assign in_bytes.ready = take_state && out_bytes.ready;
    assign in_fire        = in_bytes.valid && in_bytes.ready;
    assign in_bytes.mark  = in_fire && last_in;

    assign out_valid_c     = (state == S_COPY_WR) || ((state == S_LIT) && in_bytes.valid);
    assign out_data_c      = (state == S_COPY_WR) ? hist_rd_data : in_bytes.data;
    assign out_bytes.valid = out_valid_c;
    assign out_bytes.data  = out_data_c;
    assign out_bytes.mark  = (remain == 1);
    assign out_fire        = out_valid_c && out_bytes.ready;

    // Every emitted byte lands in the history
    assign hist_wr_en   = out_fire;
    assign hist_wr_addr = wr_ptr;
    assign hist_wr_data = out_data_c;
    assign hist_rd_addr = copy_src;

    ////////////////////////////////////////////////////////////
    // Parser FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            remain    <= '0;
            len_shift <= '0;
            wr_ptr    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    remain <= '0;
                    state  <= S_LEN;
                end
                S_LEN: if (in_fire) begin
                    remain    <= len_next;
                    len_shift <= len_shift + 6'd7;
                    if (!in_bytes.data[7]) begin
                        len_shift <= '0;
                        if (len_next != '0) begin
                            state <= S_TAG;
                        end
                    end
                end
                S_TAG: if (in_fire) begin
                    case (tag.long_view.tag)
                        snappy_pkg::TAG_LITERAL: begin
                            if (tag.long_view.len_code <= snappy_pkg::LIT_INLINE_MAX) begin
                                count <= snappy_pkg::block_len_t'(tag.long_view.len_code) + 1'b1;
                                state <= S_LIT;
                            end else begin
                                count  <= '0;
                                lb_idx <= '0;
                                lb_cnt <= 2'(tag.long_view.len_code
                                             - 6'(snappy_pkg::LIT_INLINE_MAX + 1));
                                state  <= S_LITLEN;
                            end
                        end
                        snappy_pkg::TAG_COPY1: begin
                            count     <= snappy_pkg::block_len_t'(tag.short_view.len_code)
                                         + snappy_pkg::COPY1_LEN_BASE;
                            off_q     <= {5'b00000, tag.short_view.off_hi};
                            short_off <= 1'b1;
                            state     <= S_OFF_LO;
                        end
                        default: begin
                            count     <= snappy_pkg::block_len_t'(tag.long_view.len_code) + 1'b1;
                            short_off <= 1'b0;
                            state     <= S_OFF_LO;
                        end
                    endcase
                end
                S_LITLEN: if (in_fire) begin
                    lb_idx <= lb_idx + 1'b1;
                    if (lb_idx == lb_cnt) begin
                        count <= lit_len_next + 1'b1;
                        state <= S_LIT;
                    end else begin
                        count <= lit_len_next;
                    end
                end
                S_LIT: if (out_fire) begin
                    if (remain == 1) begin
                        state <= S_LEN;
                    end else if (count == 1) begin
                        state <= S_TAG;
                    end
                end
                S_OFF_LO: if (in_fire) begin
                    if (short_off) begin
                        copy_src <= wr_ptr - HIST_ADDR_W'(offset);
                        state    <= S_COPY_RD;
                    end else begin
                        off_q <= in_bytes.data;
                        state <= S_OFF_HI;
                    end
                end
                S_OFF_HI: if (in_fire) begin
                    copy_src <= wr_ptr - HIST_ADDR_W'(offset);
                    state    <= S_COPY_RD;
                end
                S_COPY_RD: state <= S_COPY_WR;
                S_COPY_WR: if (out_fire) begin
                    copy_src <= copy_src + 1'b1;
                    if (remain == 1) begin
                        state <= S_LEN;
                    end else if (count == 1) begin
                        state <= S_TAG;
                    end else begin
                        state <= S_COPY_RD;
                    end
                end
                default: state <= S_IDLE;
            endcase

            if (out_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
                remain <= remain - 1'b1;
                count  <= count - 1'b1;
            end
        end
    end

endmodule

/* design/snappy_decompressor.sv */
`timescale 1ns/10ps

module snappy_decompressor #(
    parameter int WORD_BYTES  = 64,
    parameter int HIST_ADDR_W = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [8*WORD_BYTES-1:0] in_data,
    input  logic                    in_valid,
    output logic                    in_ready,
    output logic [8*WORD_BYTES-1:0] out_data,
    output logic                    out_valid,
    output logic                    out_last,
    input  logic                    out_ready
);

    logic                   hist_wr_en;
    logic [HIST_ADDR_W-1:0] hist_wr_addr;
    logic [7:0]             hist_wr_data;
    logic [HIST_ADDR_W-1:0] hist_rd_addr;
    logic [7:0]             hist_rd_data;

    byte_stream_if in_bytes ();
    byte_stream_if out_bytes ();

    word_unpacker #(
        .WORD_BYTES (WORD_BYTES)
    ) u_unpacker (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .bytes    (in_bytes.source)
    );

    snappy_decoder #(
        .HIST_ADDR_W (HIST_ADDR_W)
    ) u_decoder (
        .clk          (clk),
        .rst          (rst),
        .in_bytes     (in_bytes.sink),
        .out_bytes    (out_bytes.source),
        .hist_wr_en   (hist_wr_en),
        .hist_wr_addr (hist_wr_addr),
        .hist_wr_data (hist_wr_data),
        .hist_rd_addr (hist_rd_addr),
        .hist_rd_data (hist_rd_data)
    );

    history_buffer #(
        .HIST_ADDR_W (HIST_ADDR_W)
    ) u_history (
        .clk     (clk),
        .wr_en   (hist_wr_en),
        .wr_addr (hist_wr_addr),
        .wr_data (hist_wr_data),
        .rd_addr (hist_rd_addr),
        .rd_data (hist_rd_data)
    );

    word_packer #(
        .WORD_BYTES (WORD_BYTES)
    ) u_packer (
        .clk       (clk),
        .rst       (rst),
        .bytes     (out_bytes.sink),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

endmodule

/* design/snappy_pkg.sv */
package snappy_pkg;

    // Element tag in the low two bits of every tag byte
    typedef enum logic [1:0] {
        TAG_LITERAL = 2'b00,
        TAG_COPY1   = 2'b01,
        TAG_COPY2   = 2'b10,
        TAG_COPY4   = 2'b11
    } tag_e;

    // Two readings of one tag byte
    typedef union packed {
        // Literals and copies with a 2-byte offset
        struct packed {
            logic [5:0] len_code;
            tag_e       tag;
        } long_view;
        // Copies with a 1-byte offset
        struct packed {
            logic [2:0] off_hi;
            logic [2:0] len_code;
            tag_e       tag;
        } short_view;
    } tag_byte_u;

    // Block lengths and element byte counts
    typedef logic [31:0] block_len_t;

    // Codes 60 to 63 mean 1 to 4 extra length bytes follow
    localparam int unsigned LIT_INLINE_MAX = 59;

    localparam int unsigned COPY1_LEN_BASE = 4;

endpackage

/* design/word_packer.sv */
`timescale 1ns/10ps

module word_packer #(
    parameter int WORD_BYTES = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    byte_stream_if.sink             bytes,
    output logic [8*WORD_BYTES-1:0] out_data,
    output logic                    out_valid,
    output logic                    out_last,
    input  logic                    out_ready
);

    localparam int IDX_W = $clog2(WORD_BYTES);
    localparam logic [IDX_W-1:0] LAST_POS = IDX_W'(WORD_BYTES - 1);

    logic [IDX_W-1:0] pos_q;
    logic             in_fire;

    // Nothing is taken while a finished word waits
    assign bytes.ready = ~out_valid;
    assign in_fire     = bytes.valid && bytes.ready;

    ////////////////////////////////////////////////////////////
    // Byte gathering
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_data  <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            pos_q     <= '0;
        end else if (out_valid) begin
            if (out_ready) begin
                out_data  <= '0;
                out_valid <= 1'b0;
                out_last  <= 1'b0;
            end
        end else if (in_fire) begin
            out_data[{pos_q, 3'b000} +: 8] <= bytes.data;
            if (bytes.mark || pos_q == LAST_POS) begin
                out_valid <= 1'b1;
                out_last  <= bytes.mark;
                pos_q     <= '0;
            end else begin
                pos_q <= pos_q + 1'b1;
            end
        end
    end

endmodule

/* design/word_unpacker.sv */
`timescale 1ns/10ps

module word_unpacker #(
    parameter int WORD_BYTES = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [8*WORD_BYTES-1:0] in_data,
    input  logic                    in_valid,
    output logic                    in_ready,
    byte_stream_if.source           bytes
);

    localparam int IDX_W = $clog2(WORD_BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(WORD_BYTES - 1);

    logic [8*WORD_BYTES-1:0] word_q;
    logic [IDX_W-1:0]        idx_q;
    logic                    have_word;
    logic                    take;
    logic                    drop;

    assign take = have_word && bytes.ready;
    // Sink asks to throw away the rest of the word
    assign drop = bytes.mark;

    assign bytes.valid = have_word;
    assign bytes.data  = word_q[{idx_q, 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            word_q <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            have_word <= 1'b0;
            in_ready  <= 1'b0;
            idx_q     <= '0;
        end else if (in_valid && in_ready) begin
            have_word <= 1'b1;
            in_ready  <= 1'b0;
            idx_q     <= '0;
        end else if (have_word && (drop || (take && idx_q == LAST_IDX))) begin
            have_word <= 1'b0;
            in_ready  <= 1'b1;
        end else begin
            if (take) begin
                idx_q <= idx_q + 1'b1;
            end
            in_ready <= ~have_word;
        end
    end

endmodule

/* sources.f */
+incdir+verif
design/snappy_pkg.sv
design/byte_stream_if.sv
design/word_unpacker.sv
design/history_buffer.sv
design/snappy_decoder.sv
design/word_packer.sv
design/snappy_decompressor.sv
verif/tb_snappy_decompressor.sv

/* verif/snappy_model.svh */
// Element mix selectors for the block generator
localparam int GEN_LIT  = 1;
localparam int GEN_LONG = 2;
localparam int GEN_COPY = 4;

logic [7:0] comp_q[$];
logic [7:0] exp_q[$];

// Random compressed block of len bytes into comp_q
task automatic gen_block(input int unsigned len, input int kinds);
    int unsigned done;
    int unsigned rem;
    int unsigned n;
    int unsigned off;
    int unsigned nb;
    int unsigned sel;
    comp_q.delete();
    for (n = len; n >= 128; n = n >> 7) begin
        comp_q.push_back(8'h80 | 8'(n));
    end
    comp_q.push_back(8'(n));
    done = 0;
    while (done < len) begin
        rem = len - done;
        sel = $urandom_range(3, 0);
        // Bias toward offsets shorter than the copy
        off = (sel == 0) ? 1 : (sel == 1) ? $urandom_range((done < 8) ? done : 8, 1)
                                          : $urandom_range(done, 1);
        if ((kinds & GEN_COPY) != 0 && done > 0 && $urandom_range(1, 0) == 1) begin
            if (rem >= snappy_pkg::COPY1_LEN_BASE && off < 2048
                    && $urandom_range(1, 0) == 1) begin
                n = $urandom_range((rem < 11) ? rem : 11, snappy_pkg::COPY1_LEN_BASE);
                comp_q.push_back({3'(off >> 8), 3'(n - snappy_pkg::COPY1_LEN_BASE),
                                  snappy_pkg::TAG_COPY1});
                comp_q.push_back(8'(off));
            end else begin
                n = $urandom_range((rem < 64) ? rem : 64, 1);
                comp_q.push_back({6'(n - 1), snappy_pkg::TAG_COPY2});
                comp_q.push_back(8'(off));
                comp_q.push_back(8'(off >> 8));
            end
        end else begin
            if ((kinds & GEN_LONG) != 0
                    && ((kinds & GEN_LIT) == 0 || $urandom_range(2, 0) == 0)) begin
                n = $urandom_range((rem < 400) ? rem : 400, 1);
                nb = (n > 256) ? 2 : $urandom_range(2, 1);
                comp_q.push_back({6'(snappy_pkg::LIT_INLINE_MAX + nb), snappy_pkg::TAG_LITERAL});
                comp_q.push_back(8'(n - 1));
                if (nb == 2) begin
                    comp_q.push_back(8'((n - 1) >> 8));
                end
            end else begin
                n = $urandom_range((rem < 60) ? rem : 60, 1);
                comp_q.push_back({6'(n - 1), snappy_pkg::TAG_LITERAL});
            end
            repeat (n) comp_q.push_back(8'($urandom));
        end
        done = done + n;
    end
endtask

// Reference decoder working from comp_q only
function automatic void ref_decompress();
    int unsigned p;
    int unsigned len;
    int unsigned sh;
    int unsigned n;
    int unsigned nb;
    int unsigned off;
    logic [7:0] b;
    snappy_pkg::tag_e tag;
    exp_q.delete();
    p = 0;
    len = 0;
    sh = 0;
    do begin
        b = comp_q[p];
        p++;
        len = len | (32'(b[6:0]) << sh);
        sh = sh + 7;
    end while (b[7]);
    while (exp_q.size() < len) begin
        b = comp_q[p];
        p++;
        tag = snappy_pkg::tag_e'(b[1:0]);
        case (tag)
            snappy_pkg::TAG_LITERAL: begin
                n = b[7:2];
                if (n > snappy_pkg::LIT_INLINE_MAX) begin
                    nb = n - snappy_pkg::LIT_INLINE_MAX;
                    n = 0;
                    for (int i = 0; i < nb; i++) begin
                        n = n | (32'(comp_q[p]) << (8 * i));
                        p++;
                    end
                end
                repeat (n + 1) begin
                    exp_q.push_back(comp_q[p]);
                    p++;
                end
            end
            snappy_pkg::TAG_COPY1: begin
                n = b[4:2] + snappy_pkg::COPY1_LEN_BASE;
                off = {b[7:5], comp_q[p]};
                p++;
            end
            default: begin
                n = b[7:2] + 1;
                off = {comp_q[p + 1], comp_q[p]};
                p = p + 2;
            end
        endcase
        if (tag != snappy_pkg::TAG_LITERAL) begin
            repeat (n) exp_q.push_back(exp_q[exp_q.size() - off]);
        end
    end
endfunction

/* verif/tb_snappy_decompressor.sv */
`timescale 1ns/10ps

module tb_snappy_decompressor;

    localparam int WORD_BYTES = 64;
    localparam int WORD_W     = 8 * WORD_BYTES;
    localparam int WAIT_LIMIT = 20000;

    logic              clk;
    logic              rst;
    logic [WORD_W-1:0] in_data;
    logic              in_valid;
    logic              in_ready;
    logic [WORD_W-1:0] out_data;
    logic              out_valid;
    logic              out_last;
    logic              out_ready;

    logic [WORD_W-1:0] in_words[$];
    logic [WORD_W-1:0] exp_words[$];
    logic              exp_lasts[$];
    int                err_count;
    int                pass_count;
    int                fail_count;
    int                gap_pct;
    int                stall_pct;
    bit                timed_out;

    `include "snappy_model.svh"

    snappy_decompressor u_snappy_decompressor (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [WORD_W-1:0] exp_val,
                               input logic [WORD_W-1:0] act_val);
        if (exp_val !== act_val) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp_val, act_val);
            err_count++;
        end
    endtask

    // One block into input words and expected output words
    task automatic add_block(input int unsigned len, input int kinds);
        logic [WORD_W-1:0] w;
        gen_block(len, kinds);
        ref_decompress();
        for (int i = 0; i < comp_q.size(); i += WORD_BYTES) begin
            for (int k = 0; k < WORD_BYTES; k++) begin
                // junk after the block end
                w[8*k +: 8] = (i + k < comp_q.size()) ? comp_q[i + k] : 8'($urandom);
            end
            in_words.push_back(w);
        end
        for (int i = 0; i < exp_q.size(); i += WORD_BYTES) begin
            w = '0;
            for (int k = 0; k < WORD_BYTES && i + k < exp_q.size(); k++) begin
                w[8*k +: 8] = exp_q[i + k];
            end
            exp_words.push_back(w);
            exp_lasts.push_back(i + WORD_BYTES >= exp_q.size());
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Input driver and output monitor
    ////////////////////////////////////////////////////////////

    task automatic send_words();
        int waited;
        for (int i = 0; i < in_words.size() && !timed_out; i++) begin
            if ($urandom_range(99, 0) < gap_pct) begin
                repeat ($urandom_range(3, 1)) @(negedge clk);
            end
            in_data  = in_words[i];
            in_valid = 1'b1;
            waited   = 0;
            while (!in_ready && waited < WAIT_LIMIT && !timed_out) begin
                @(negedge clk);
                waited++;
            end
            if (!in_ready && !timed_out) begin
                $display("Timeout: input word %0d was never accepted", i);
                timed_out = 1'b1;
            end
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic collect_words(input string name);
        int waited;
        bit got;
        for (int i = 0; i < exp_words.size() && !timed_out; i++) begin
            got    = 1'b0;
            waited = 0;
            while (!got && waited < WAIT_LIMIT && !timed_out) begin
                @(negedge clk);
                out_ready = ($urandom_range(99, 0) >= stall_pct);
                if (out_valid && out_ready) begin
                    check_value({name, " data"}, exp_words[i], out_data);
                    check_value({name, " last"}, WORD_W'(exp_lasts[i]), WORD_W'(out_last));
                    got = 1'b1;
                end
                waited++;
            end
            if (!got && !timed_out) begin
                $display("Timeout: output word %0d of %s never arrived", i, name);
                timed_out = 1'b1;
            end
        end
        out_ready = 1'b1;
        // Nothing more may come out
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!timed_out && !out_valid && waited < 20);
        check_value({name, " extra word"}, '0, WORD_W'(out_valid));
    endtask

    task automatic run_test(input string name, input int gap, input int stall);
        err_count = 0;
        gap_pct   = gap;
        stall_pct = stall;
        if (timed_out) begin
            $display("%s: skipped after a timeout", name);
        end else begin
            @(negedge clk);
            fork
                send_words();
                collect_words(name);
            join
            if (err_count == 0 && !timed_out) begin
                pass_count++;
                $display("%s: PASS", name);
            end else begin
                fail_count++;
                $display("%s: FAIL with %0d mismatches", name, err_count);
            end
        end
        in_words.delete();
        exp_words.delete();
        exp_lasts.delete();
    endtask

    initial begin
        void'($urandom(32'h560f97d7));
        rst        = 1'b1;
        in_data    = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        gap_pct    = 0;
        stall_pct  = 0;
        timed_out  = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        for (int b = 0; b < 4; b++) begin
            add_block($urandom_range(200, 1), GEN_LIT);
        end
        run_test("short_literals", 0, 0);
        for (int b = 0; b < 3; b++) begin
            add_block($urandom_range(700, 100), GEN_LONG);
        end
        run_test("long_literals", 0, 0);
        for (int b = 0; b < 4; b++) begin
            add_block($urandom_range(400, 40), GEN_LIT | GEN_COPY);
        end
        run_test("copies", 0, 0);
        for (int b = 0; b < 8; b++) begin
            add_block($urandom_range(90, 1), GEN_LIT | GEN_LONG | GEN_COPY);
        end
        run_test("back_to_back", 0, 0);
        for (int b = 0; b < 20; b++) begin
            add_block($urandom_range(1500, 1), GEN_LIT | GEN_LONG | GEN_COPY);
        end
        run_test("random_stress", 30, 40);

        $display("Summary: %0d passing, %0d failing", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
